// ==== logic/video_rx_pkg.sv ====
package video_rx_pkg;

    localparam int addr_bytes      = 3;
    localparam int pixels_per_line = 320;
    localparam int pixel_index_w   = 9;
    localparam int pixel_words     = pixels_per_line / 4;
    localparam int audio_depth     = 16;
    localparam int axil_addr_w     = 12;
    localparam int axil_data_w     = 32;

    typedef enum logic [1:0] {addr_beat, pixel_beat, audio_beat, end_beat} beat_kind_t;

    typedef enum logic [1:0] {st_addr, st_pixel, st_audio} dec_state_t;

    typedef enum logic [1:0] {rd_idle, rd_fetch, rd_respond} rd_state_t;

    typedef struct packed {
        logic                     valid;
        beat_kind_t               kind;
        logic [7:0]               data;
        logic [pixel_index_w-1:0] index;
    } rx_beat_t;

    typedef struct packed {
        logic [23:0] line_addr;
        logic [15:0] packet_count;
        logic [15:0] audio_overflow;
        logic [4:0]  audio_level;
    } rx_status_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } audio_pop_t;

    localparam logic [axil_addr_w-1:0] reg_status    = 12'h000;
    localparam logic [axil_addr_w-1:0] reg_line_addr = 12'h004;
    localparam logic [axil_addr_w-1:0] reg_overflow  = 12'h008;
    localparam logic [axil_addr_w-1:0] reg_audio     = 12'h00C; // read pops, write clears counts
    localparam logic [axil_addr_w-1:0] reg_pixels    = 12'h100;

endpackage

// ==== logic/packet_field_decoder.sv ====
`timescale 1ns/1ps

module packet_field_decoder
    import video_rx_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       rx_valid,
    input  logic [1:0] rx_symbol,
    output rx_beat_t   beat
);

    dec_state_t               state;
    logic [1:0]               sym_count;   // symbols taken in the current byte
    logic [5:0]               byte_shift;  // first three symbols of the byte
    logic [pixel_index_w-1:0] byte_count;
    logic                     end_pending;
    logic [7:0]               next_byte;

    assign next_byte = {byte_shift, rx_symbol};

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= st_addr;
            sym_count   <= 2'd0;
            byte_count  <= '0;
            end_pending <= 1'b0;
            beat.valid  <= 1'b0;
        end else begin
            beat.valid  <= 1'b0;
            end_pending <= 1'b0;

            // the line is complete, so the end beat goes out even if valid drops here
            if (end_pending) begin
                beat.valid <= 1'b1;
                beat.kind  <= end_beat;
                beat.data  <= 8'd0;
                beat.index <= '0;
            end

            if (!rx_valid) begin
                state      <= st_addr; // a partial byte is simply forgotten
                sym_count  <= 2'd0;
                byte_count <= '0;
            end else begin
                sym_count  <= sym_count + 2'd1;
                byte_shift <= {byte_shift[3:0], rx_symbol};

                if (sym_count == 2'd3) begin
                    beat.valid <= 1'b1;
                    beat.data  <= next_byte;
                    beat.index <= byte_count;

                    case (state)
                        st_addr: begin
                            beat.kind <= addr_beat;
                            if (byte_count == pixel_index_w'(addr_bytes - 1)) begin
                                state      <= st_pixel;
                                byte_count <= '0;
                            end else begin
                                byte_count <= byte_count + 1'b1;
                            end
                        end
                        st_pixel: begin
                            beat.kind <= pixel_beat;
                            if (byte_count == pixel_index_w'(pixels_per_line - 1)) begin
                                state       <= st_audio;
                                byte_count  <= '0;
                                end_pending <= 1'b1;
                            end else begin
                                byte_count <= byte_count + 1'b1;
                            end
                        end
                        st_audio: begin
                            beat.kind <= audio_beat; // audio runs until valid falls
                        end
                        default: begin
                            state <= st_addr;
                        end
                    endcase
                end
            end
        end
    end

endmodule

// ==== logic/line_buffer_writer.sv ====
`timescale 1ns/1ps

module line_buffer_writer
    import video_rx_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  rx_beat_t                 beat,
    input  logic [pixel_index_w-3:0] pix_rd_word,
    output logic [31:0]              pix_rd_data,
    input  logic                     audio_pop,
    output audio_pop_t               audio_head,
    input  logic                     clear_counts,
    output rx_status_t               status
);

    logic [3:0][7:0]                pix_mem [pixel_words]; // four pixels per word, low index low
    logic [7:0]                     audio_mem [audio_depth];
    logic [$clog2(audio_depth)-1:0] wr_ptr;
    logic [$clog2(audio_depth)-1:0] rd_ptr;
    logic                           pixel_we;
    logic                           audio_full;
    logic                           audio_push;
    logic                           audio_drop;
    logic                           audio_take;

    assign pixel_we   = beat.valid && beat.kind == pixel_beat;
    assign audio_full = status.audio_level == 5'(audio_depth);
    assign audio_push = beat.valid && beat.kind == audio_beat && !audio_full;
    assign audio_drop = beat.valid && beat.kind == audio_beat && audio_full;
    assign audio_take = audio_pop && audio_head.valid; // popping an empty queue does nothing

    assign audio_head.valid = status.audio_level != 5'd0;
    assign audio_head.data  = audio_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (pixel_we) begin
            pix_mem[beat.index[pixel_index_w-1:2]][beat.index[1:0]] <= beat.data;
        end
        pix_rd_data <= pix_mem[pix_rd_word];
    end

    always_ff @(posedge clk) begin
        if (audio_push) begin
            audio_mem[wr_ptr] <= beat.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            status <= '0;
        end else begin
            if (beat.valid && beat.kind == addr_beat) begin
                status.line_addr <= {status.line_addr[15:0], beat.data}; // msb first
            end
            if (beat.valid && beat.kind == end_beat) begin
                status.packet_count <= status.packet_count + 16'd1;
            end
            if (audio_drop) begin
                status.audio_overflow <= status.audio_overflow + 16'd1;
            end
            if (clear_counts) begin
                status.packet_count   <= 16'd0;
                status.audio_overflow <= 16'd0;
            end

            if (audio_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (audio_take) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({audio_push, audio_take})
                2'b10:   status.audio_level <= status.audio_level + 5'd1;
                2'b01:   status.audio_level <= status.audio_level - 5'd1;
                default: status.audio_level <= status.audio_level;
            endcase
        end
    end

endmodule

// ==== logic/rx_status_axil.sv ====
`timescale 1ns/1ps

module rx_status_axil
    import video_rx_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic [axil_addr_w-1:0]   awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [axil_data_w-1:0]   wdata,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  logic [axil_addr_w-1:0]   araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [axil_data_w-1:0]   rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready,
    input  rx_status_t               status,
    input  audio_pop_t               audio_head,
    output logic [pixel_index_w-3:0] pix_rd_word,
    input  logic [31:0]              pix_rd_data,
    output logic                     audio_pop,
    output logic                     clear_counts
);

    rd_state_t                rd_state;
    logic [axil_addr_w-1:0]   rd_addr;
    logic [axil_addr_w-1:0]   pix_offset;
    audio_pop_t               audio_q;    // queue head as it was when the read was accepted
    logic                     fetch_step;
    logic                     aw_fire;
    logic                     ar_fire;
    logic                     rd_is_pixel;
    logic [axil_data_w-1:0]   rd_word;

    // write channel, address and data are taken together
    assign aw_fire      = awvalid && wvalid && !bvalid;
    assign awready      = !bvalid;
    assign wready       = !bvalid;
    assign bresp        = 2'b00;
    assign clear_counts = aw_fire && awaddr == reg_audio; // the data word itself is don't-care

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
        end else if (aw_fire) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    assign arready   = rd_state == rd_idle;
    assign ar_fire   = arvalid && arready;
    assign audio_pop = ar_fire && araddr == reg_audio;
    assign rresp     = 2'b00;

    assign pix_offset  = rd_addr - reg_pixels;
    assign pix_rd_word = pix_offset[pixel_index_w-1:2];
    assign rd_is_pixel = rd_addr >= reg_pixels && pix_offset < axil_addr_w'(pixel_words * 4);

    always_comb begin
        rd_word = '0;
        case (rd_addr)
            reg_status: begin
                rd_word[15:0]  = status.packet_count;
                rd_word[20:16] = status.audio_level;
            end
            reg_line_addr: begin
                rd_word[23:0] = status.line_addr;
            end
            reg_overflow: begin
                rd_word[15:0] = status.audio_overflow;
            end
            reg_audio: begin
                rd_word[8:0] = {audio_q.valid, audio_q.data};
            end
            default: begin
                if (rd_is_pixel) begin
                    rd_word = pix_rd_data;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rd_addr <= araddr;
            audio_q <= audio_head;
        end
        if (rd_state == rd_fetch && fetch_step) begin
            rdata <= rd_word;
        end
    end

    // fetch takes two cycles so the memory word is registered before the mux
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state   <= rd_idle;
            fetch_step <= 1'b0;
            rvalid     <= 1'b0;
        end else begin
            case (rd_state)
                rd_idle: begin
                    if (ar_fire) begin
                        rd_state   <= rd_fetch;
                        fetch_step <= 1'b0;
                    end
                end
                rd_fetch: begin
                    fetch_step <= 1'b1;
                    if (fetch_step) begin
                        rd_state <= rd_respond;
                        rvalid   <= 1'b1;
                    end
                end
                rd_respond: begin
                    if (rready) begin
                        rd_state <= rd_idle;
                        rvalid   <= 1'b0;
                    end
                end
                default: begin
                    rd_state <= rd_idle;
                end
            endcase
        end
    end

endmodule

// ==== logic/video_packet_rx.sv ====
`timescale 1ns/1ps

module video_packet_rx
    import video_rx_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rx_valid,
    input  logic [1:0]             rx_symbol,
    input  logic [axil_addr_w-1:0] awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [axil_data_w-1:0] wdata,
    input  logic                   wvalid,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  logic                   bready,
    input  logic [axil_addr_w-1:0] araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [axil_data_w-1:0] rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  logic                   rready
);

    rx_beat_t                 beat;
    rx_status_t               status;
    audio_pop_t               audio_head;
    logic [pixel_index_w-3:0] pix_rd_word;
    logic [31:0]              pix_rd_data;
    logic                     audio_pop;
    logic                     clear_counts;

    packet_field_decoder i_packet_field_decoder (
        .clk       (clk),
        .rst       (rst),
        .rx_valid  (rx_valid),
        .rx_symbol (rx_symbol),
        .beat      (beat)
    );

    line_buffer_writer i_line_buffer_writer (
        .clk          (clk),
        .rst          (rst),
        .beat         (beat),
        .pix_rd_word  (pix_rd_word),
        .pix_rd_data  (pix_rd_data),
        .audio_pop    (audio_pop),
        .audio_head   (audio_head),
        .clear_counts (clear_counts),
        .status       (status)
    );

    rx_status_axil i_rx_status_axil (
        .clk          (clk),
        .rst          (rst),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wvalid       (wvalid),
        .wready       (wready),
        .bresp        (bresp),
        .bvalid       (bvalid),
        .bready       (bready),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rvalid       (rvalid),
        .rready       (rready),
        .status       (status),
        .audio_head   (audio_head),
        .pix_rd_word  (pix_rd_word),
        .pix_rd_data  (pix_rd_data),
        .audio_pop    (audio_pop),
        .clear_counts (clear_counts)
    );

endmodule

// ==== bench/video_packet_rx_tb.sv ====
`timescale 1ns/1ps

module video_packet_rx_tb
    import video_rx_pkg::*;
();

    localparam int timeout_cycles = 20000; // tests take about 8000 cycles, five packets and 370 reads

    logic                   clk;
    logic                   rst;
    logic                   rx_valid;
    logic [1:0]             rx_symbol;
    logic [axil_addr_w-1:0] awaddr;
    logic                   awvalid;
    logic                   awready;
    logic [axil_data_w-1:0] wdata;
    logic                   wvalid;
    logic                   wready;
    logic [1:0]             bresp;
    logic                   bvalid;
    logic                   bready;
    logic [axil_addr_w-1:0] araddr;
    logic                   arvalid;
    logic                   arready;
    logic [axil_data_w-1:0] rdata;
    logic [1:0]             rresp;
    logic                   rvalid;
    logic                   rready;

    logic [31:0] lfsr = 32'heb32;
    int          cycles = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          test_start_errors;
    logic [7:0]  exp_mem [pixels_per_line];
    logic [7:0]  audio_model [$];
    rx_status_t  exp_status;

    video_packet_rx i_video_packet_rx (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == timeout_cycles) begin
            $display("timeout after %0d cycles, the DUT never finished a transfer", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    task automatic compare_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_audio(input audio_pop_t got, input audio_pop_t exp);
        checks++;
        // the data byte means nothing once the queue is empty
        if (got.valid !== exp.valid || (exp.valid && got.data !== exp.data)) begin
            errors++;
            $display("FAIL %0t audio_head: got %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic compare_status(input rx_status_t got, input rx_status_t exp);
        checks++;
        if (got.line_addr !== exp.line_addr) begin
            errors++;
            $display("FAIL %0t line_addr: got %h, expected %h", $time, got.line_addr, exp.line_addr);
        end
        if (got.packet_count !== exp.packet_count) begin
            errors++;
            $display("FAIL %0t packet_count: got %h, expected %h", $time, got.packet_count,
                     exp.packet_count);
        end
        if (got.audio_overflow !== exp.audio_overflow) begin
            errors++;
            $display("FAIL %0t audio_overflow: got %h, expected %h", $time, got.audio_overflow,
                     exp.audio_overflow);
        end
        if (got.audio_level !== exp.audio_level) begin
            errors++;
            $display("FAIL %0t audio_level: got %h, expected %h", $time, got.audio_level,
                     exp.audio_level);
        end
    endtask

    task automatic axil_read(input logic [axil_addr_w-1:0] addr, output logic [31:0] data);
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        arvalid <= 1'b0;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        data = rdata;
        compare_word("rresp", 32'(rresp), 32'd0);
        @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic axil_write(input logic [axil_addr_w-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        @(negedge clk);
        while (!(awready && wready)) @(negedge clk);
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        compare_word("bresp", 32'(bresp), 32'd0);
        @(posedge clk);
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic send_byte(input logic [7:0] b);
        for (int k = 3; k >= 0; k--) begin
            @(posedge clk);
            rx_valid  <= 1'b1;
            rx_symbol <= b[2*k +: 2]; // first symbol is the top pair
        end
    endtask

    // a packet with fewer than a full line of pixels is an abort
    task automatic send_packet(input logic [23:0] addr, input int n_pix, input int n_audio);
        logic [7:0] b;
        for (int i = 2; i >= 0; i--) begin
            send_byte(addr[8*i +: 8]);
        end
        exp_status.line_addr = addr;
        for (int i = 0; i < n_pix; i++) begin
            b = 8'(rand_bits(8));
            exp_mem[i] = b;
            send_byte(b);
        end
        if (n_pix == pixels_per_line) begin
            exp_status.packet_count++;
            for (int i = 0; i < n_audio; i++) begin
                b = 8'(rand_bits(8));
                if (audio_model.size() < audio_depth) begin
                    audio_model.push_back(b);
                end else begin
                    exp_status.audio_overflow++;
                end
                send_byte(b);
            end
        end
        @(posedge clk);
        rx_valid <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    task automatic check_status();
        logic [31:0] w;
        rx_status_t  got;
        got = '0;
        axil_read(reg_status, w);
        got.packet_count = w[15:0];
        got.audio_level  = w[20:16];
        axil_read(reg_line_addr, w);
        got.line_addr = w[23:0];
        axil_read(reg_overflow, w);
        got.audio_overflow = w[15:0];
        exp_status.audio_level = 5'(audio_model.size());
        compare_status(got, exp_status);
    endtask

    task automatic check_pixels();
        logic [31:0] w;
        for (int i = 0; i < pixels_per_line / 4; i++) begin
            axil_read(reg_pixels + axil_addr_w'(i * 4), w);
            compare_word($sformatf("pixel word %0d", i), w,
                         {exp_mem[4*i+3], exp_mem[4*i+2], exp_mem[4*i+1], exp_mem[4*i]});
        end
    endtask

    // pops everything the model holds, then expects an empty queue
    task automatic drain_audio();
        logic [31:0] w;
        audio_pop_t  exp;
        while (audio_model.size() > 0) begin
            axil_read(reg_audio, w);
            exp.valid = 1'b1;
            exp.data  = audio_model.pop_front();
            compare_audio(audio_pop_t'(w[8:0]), exp);
        end
        axil_read(reg_audio, w);
        exp = '0;
        compare_audio(audio_pop_t'(w[8:0]), exp);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("%s: %0d errors", name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        rx_valid = 1'b0;
        rx_symbol = 2'd0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        exp_status = '0;
        test_start_errors = 0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        check_status();
        drain_audio();
        end_test("reset values");

        send_packet(24'(rand_bits(24)), pixels_per_line, 0);
        check_status();
        check_pixels();
        end_test("full packet");

        send_packet(24'(rand_bits(24)), pixels_per_line, 6);
        check_status();
        drain_audio();
        check_status();
        end_test("audio order");

        send_packet(24'(rand_bits(24)), 100, 0);
        check_status();
        check_pixels();
        send_packet(24'(rand_bits(24)), pixels_per_line, 0);
        check_status();
        check_pixels();
        end_test("aborted packet");

        send_packet(24'(rand_bits(24)), pixels_per_line, 20);
        check_status();
        end_test("audio overflow");

        axil_write(reg_audio, 32'd0);
        exp_status.packet_count   = 16'd0;
        exp_status.audio_overflow = 16'd0;
        check_status();
        check_pixels();
        drain_audio();
        end_test("clear counts");

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== video_packet_rx.f ====
logic/video_rx_pkg.sv
logic/packet_field_decoder.sv
logic/line_buffer_writer.sv
logic/rx_status_axil.sv
logic/video_packet_rx.sv
bench/video_packet_rx_tb.sv

// ==== Makefile ====
TOP = video_packet_rx_tb

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f video_packet_rx.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
